// File: Makefile
# Verilator build and run of the video output stage testbench

VERILATOR ?= verilator
TOP       ?= tb_video_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
SIM_ARGS  ?=

.PHONY: sim clean

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tb_video_top.sv
module tb_video_top import video_pkg::*; ();

	//////////////////////////////////////////////////
	// Run length
	//////////////////////////////////////////////////

	localparam int MIX_CYCLES = 1000;
	localparam int BLANK_CYCLES = 60;
	// Reset, palette load, both sweep banks and the drain
	localparam int LOAD_CYCLES = 3 + PAL_DEPTH + PAL_DEPTH + 2;
	// Bank toggle, after blank, ladder load and ladder sweep
	localparam int SHORT_CYCLES = 18 + 20 + 16 + 18;
	localparam int PLANNED_CYCLES = LOAD_CYCLES + MIX_CYCLES + BLANK_CYCLES + SHORT_CYCLES;
	localparam int CYCLE_LIMIT = PLANNED_CYCLES * 3 / 2;
	localparam palette_wr_t NO_WRITE = '0;

	logic         clk_6m;
	logic         rst_n;
	layer_pixel_t tile;
	layer_pixel_t sprite;
	logic         bank;
	logic         blank;
	palette_wr_t  pal_wr;
	rgb_t         rgb;

	video_top UUT (
		.clk_6m (clk_6m),
		.rst_n  (rst_n),
		.tile   (tile),
		.sprite (sprite),
		.bank   (bank),
		.blank  (blank),
		.pal_wr (pal_wr),
		.rgb    (rgb)
	);

	// 10 unit period
	always #5 clk_6m = ~clk_6m;

	// Watchdog
	int cycle_count;
	always @(posedge clk_6m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Test failed");
			$fatal(1, "Timeout, the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		end
	end

	//////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////

	logic [31:0] lfsr;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic layer_pixel_t rand_pixel();
		layer_pixel_t p;
		p.color = color_t'(rand_bits(COLOR_W));
		p.prio = prio_t'(rand_bits(PRIO_W));
		return p;
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	logic [BPP-1:0] ladder_model [16];
	// Entries as {r, g, b}
	logic [11:0]    pal_model [PAL_DEPTH];
	// Mixer stage then latch stage
	color_t         mix_model;
	color_t         idx_model;

	// Divider between set bits and clear bits
	function automatic void build_ladder_model();
		real res [4];
		real g_on;
		real g_off;
		real fs;
		res[0] = RM4;
		res[1] = RM3;
		res[2] = RM2;
		res[3] = RM1;
		fs = (2.0 ** BPP) - 1.0;
		for (int v = 0; v < 16; v++) begin
			g_on = 0.0;
			g_off = 0.0;
			for (int k = 0; k < 4; k++) begin
				if (v[k]) begin
					g_on = g_on + 1.0 / res[k];
				end else begin
					g_off = g_off + 1.0 / res[k];
				end
			end
			if (v == 0) begin
				ladder_model[4'(v)] = '0;
			end else if (v == 15) begin
				ladder_model[4'(v)] = BPP'(2 ** BPP - 1);
			end else begin
				ladder_model[4'(v)] =
					BPP'($rtoi(fs * ((1.0 / g_off) / (1.0 / g_on + 1.0 / g_off))));
			end
		end
	endfunction

	// State change at one clock edge from the inputs the DUT sees there
	function automatic void model_edge();
		if (pal_wr.we) begin
			pal_model[pal_wr.addr] = {pal_wr.r, pal_wr.g, pal_wr.b};
		end
		idx_model = blank ? '0 : mix_model;
		// Opaque sprite at equal or higher priority shows
		if (sprite.color[3:0] != TRANSPARENT_PEN && sprite.prio >= tile.prio) begin
			mix_model = sprite.color;
		end else begin
			mix_model = tile.color;
		end
	endfunction

	function automatic rgb_t entry_rgb(input logic bk, input color_t idx);
		logic [11:0] e;
		rgb_t        x;
		e = pal_model[{bk, idx}];
		x.r = ladder_model[e[11:8]];
		x.g = ladder_model[e[7:4]];
		x.b = ladder_model[e[3:0]];
		return x;
	endfunction

	//////////////////////////////////////////////////
	// Checks and stepping
	//////////////////////////////////////////////////

	task automatic check(input logic [31:0] expected, input logic [31:0] actual,
			input string what);
		if (actual !== expected) begin
			$display("ERR %0t: %s, expected %h, got %h", $time, what, expected, actual);
			$display("Test failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	// Drive at the rising edge and compare at the falling edge
	task automatic step(input layer_pixel_t t, input layer_pixel_t s, input logic bk,
			input logic bl, input palette_wr_t w, input string what);
		@(posedge clk_6m);
		model_edge();
		tile <= t;
		sprite <= s;
		bank <= bk;
		blank <= bl;
		pal_wr <= w;
		@(negedge clk_6m);
		check(32'(entry_rgb(bk, idx_model)), 32'(rgb), what);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		layer_pixel_t t;
		layer_pixel_t s;
		palette_wr_t  w;
		logic         bk;

		clk_6m = 1'b0;
		rst_n = 1'b0;
		tile = '0;
		sprite = '0;
		bank = 1'b0;
		blank = 1'b0;
		pal_wr = '0;
		lfsr = 32'h60ea;
		mix_model = '0;
		idx_model = '0;
		for (int a = 0; a < PAL_DEPTH; a++) begin
			pal_model[PAL_AW'(a)] = '0;
		end
		build_ladder_model();

		repeat (3) @(posedge clk_6m);
		rst_n <= 1'b1;

		// Reset state with a black palette
		@(negedge clk_6m);
		check(32'd0, 32'(rgb), "rgb after reset");

		// Random fill of both banks
		for (int a = 0; a < PAL_DEPTH; a++) begin
			w.we = 1'b1;
			w.addr = PAL_AW'(a);
			w.r = 4'(rand_bits(4));
			w.g = 4'(rand_bits(4));
			w.b = 4'(rand_bits(4));
			step(tile, sprite, 1'b0, 1'b0, w, "rgb during palette load");
		end

		// Every index in both banks with the sprite see-through
		for (int b = 0; b < 2; b++) begin
			for (int i = 0; i < 256; i++) begin
				t.color = color_t'(i);
				t.prio = prio_t'(rand_bits(PRIO_W));
				s.color = {4'(rand_bits(4)), TRANSPARENT_PEN};
				s.prio = prio_t'(rand_bits(PRIO_W));
				step(t, s, b[0], 1'b0, NO_WRITE, "palette sweep");
			end
		end
		repeat (2) step(t, s, 1'b1, 1'b0, NO_WRITE, "palette sweep drain");

		// Mixing with forced pens and ties
		for (int n = 0; n < MIX_CYCLES; n++) begin
			t = rand_pixel();
			s = rand_pixel();
			if (rand_bits(2) == 0) begin
				s.color[3:0] = TRANSPARENT_PEN;
			end
			if (rand_bits(2) == 0) begin
				s.prio = t.prio;
			end
			bk = 1'(rand_bits(1));
			step(t, s, bk, 1'b0, NO_WRITE, "priority mix");
		end

		// Steady pixel while bank flips every cycle
		t = rand_pixel();
		s = rand_pixel();
		repeat (2) step(t, s, 1'b0, 1'b0, NO_WRITE, "bank fill");
		for (int n = 0; n < 16; n++) begin
			step(t, s, 1'(n), 1'b0, NO_WRITE, "bank toggle");
		end

		// Blank held so the latch loads index 0
		for (int n = 0; n < BLANK_CYCLES; n++) begin
			t = rand_pixel();
			s = rand_pixel();
			bk = 1'(rand_bits(1));
			step(t, s, bk, 1'b1, NO_WRITE, "blank held");
			if (n > 0) begin
				check(32'(entry_rgb(bk, 8'h00)), 32'(rgb), "blank shows index 0");
			end
		end
		for (int n = 0; n < 20; n++) begin
			t = rand_pixel();
			s = rand_pixel();
			step(t, s, 1'(rand_bits(1)), 1'b0, NO_WRITE, "after blank");
		end

		// Codes 0 to 15 on every channel
		for (int c = 0; c < 16; c++) begin
			w.we = 1'b1;
			w.addr = PAL_AW'(c);
			w.r = 4'(c);
			w.g = 4'(15 - c);
			w.b = 4'(c);
			step(tile, sprite, 1'b0, 1'b0, w, "ladder entry load");
		end
		for (int c = 0; c < 18; c++) begin
			t.color = color_t'(c);
			t.prio = '0;
			s.color = 8'hFF;
			s.prio = '1;
			step(t, s, 1'b0, 1'b0, NO_WRITE, "ladder sweep");
			// Red carries the index as its code here
			if (idx_model == 8'd15) begin
				check(32'(2 ** BPP - 1), 32'(rgb.r), "ladder full scale");
			end else if (idx_model == 8'd0) begin
				check(32'd0, 32'(rgb.r), "ladder zero");
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

// File: logic/clut.sv
module clut import video_pkg::*; (
	input  logic        clk_6m,
	input  logic        rst_n,
	input  color_t      index,
	input  logic        bank,
	input  logic        blank,
	input  palette_wr_t pal_wr,
	output rgb_t        rgb
);

	//////////////////////////////////////////////////
	// Index latch
	//////////////////////////////////////////////////

	// The 74LS273 between mixer and palette
	color_t idx_q;

	// Blank forces pen 0 at the edge
	// Reset clears it too
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			idx_q <= '0;
		end else if (blank) begin
			idx_q <= '0;
		end else begin
			idx_q <= index;
		end
	end

	//////////////////////////////////////////////////
	// Palette memories
	//////////////////////////////////////////////////

	// Bank is not latched, it selects straight away
	logic [PAL_AW-1:0] rd_addr;
	// Green in the upper nibble, red in the lower
	logic [2*CHAN_W-1:0] gr_data;
	logic [CHAN_W-1:0]   b_data;
	// Channel codes into the ladders
	logic [CHAN_W-1:0]   r_code;
	logic [CHAN_W-1:0]   g_code;

	assign rd_addr = {bank, idx_q};

	// Green and red part
	color_ram #(
		.WIDTH(2 * CHAN_W)
	) ram_gr (
		.clk_6m (clk_6m),
		.we     (pal_wr.we),
		.waddr  (pal_wr.addr),
		.wdata  ({pal_wr.g, pal_wr.r}),
		.raddr  (rd_addr),
		.rdata  (gr_data)
	);

	// Blue part
	color_ram #(
		.WIDTH(CHAN_W)
	) ram_b (
		.clk_6m (clk_6m),
		.we     (pal_wr.we),
		.waddr  (pal_wr.addr),
		.wdata  (pal_wr.b),
		.raddr  (rd_addr),
		.rdata  (b_data)
	);

	assign r_code = gr_data[CHAN_W-1:0];
	assign g_code = gr_data[2*CHAN_W-1:CHAN_W];

	//////////////////////////////////////////////////
	// Ladders
	//////////////////////////////////////////////////

	logic [BPP-1:0] lvl_r;
	logic [BPP-1:0] lvl_g;
	logic [BPP-1:0] lvl_b;

	dac_ladder dac_r (
		.code  (r_code),
		.level (lvl_r)
	);

	dac_ladder dac_g (
		.code  (g_code),
		.level (lvl_g)
	);

	dac_ladder dac_b (
		.code  (b_data),
		.level (lvl_b)
	);

	// Pack for the monitor
	always_comb begin
		rgb.r = lvl_r;
		rgb.g = lvl_g;
		rgb.b = lvl_b;
	end

endmodule

// File: logic/color_ram.sv
module color_ram import video_pkg::*; #(
	parameter int unsigned WIDTH = 8
) (
	input  logic              clk_6m,
	input  logic              we,
	input  logic [PAL_AW-1:0] waddr,
	input  logic [WIDTH-1:0]  wdata,
	input  logic [PAL_AW-1:0] raddr,
	output logic [WIDTH-1:0]  rdata
);

	// Palette storage, stands in for one PROM
	logic [WIDTH-1:0] mem [PAL_DEPTH];

	// Palette comes up black
	initial begin
		for (int i = 0; i < PAL_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	// Load port
	// Entry changes at the strobed edge
	always_ff @(posedge clk_6m) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Read behaves like the PROM outputs
	// No clock in the read path
	assign rdata = mem[raddr];

endmodule

// File: logic/dac_ladder.sv
module dac_ladder import video_pkg::*; (
	input  logic [CHAN_W-1:0] code,
	output logic [BPP-1:0]    level
);

	// Intensity per channel code
	logic [BPP-1:0] lut [LADDER_CODES];

	//////////////////////////////////////////////////
	// Table build
	//////////////////////////////////////////////////

	// Bits at 1 pull toward the supply through r1
	// Bits at 0 pull toward ground through r2
	// Output is the divider ratio of the two sides
	initial begin
		real g_bit [CHAN_W];
		real g1;
		real g2;
		real r1;
		real r2;
		real full_scale;
		real lvl;

		// Conductance of each ladder leg
		g_bit[3] = 1.0 / RM1;
		g_bit[2] = 1.0 / RM2;
		g_bit[1] = 1.0 / RM3;
		g_bit[0] = 1.0 / RM4;

		full_scale = (2.0 ** BPP) - 1.0;

		for (int c = 0; c < LADDER_CODES; c++) begin
			if (c == 0) begin
				// Nothing on the high side
				lut[c] = '0;
			end else if (c == LADDER_CODES - 1) begin
				// Nothing on the low side
				lut[c] = BPP'($rtoi(full_scale));
			end else begin
				g1 = 0.0;
				g2 = 0.0;
				// Split legs between the two sides
				for (int b = 0; b < CHAN_W; b++) begin
					if (c[b]) begin
						g1 = g1 + g_bit[b];
					end else begin
						g2 = g2 + g_bit[b];
					end
				end
				// Parallel resistance of each side
				r1 = 1.0 / g1;
				r2 = 1.0 / g2;
				lvl = full_scale * (r2 / (r1 + r2));
				// Truncate, never round
				lut[c] = BPP'($rtoi(lvl));
			end
		end
	end

	// Conversion itself is a plain lookup
	assign level = lut[code];

endmodule

// File: logic/pixel_mixer.sv
module pixel_mixer import video_pkg::*; (
	input  logic         clk_6m,
	input  logic         rst_n,
	input  layer_pixel_t tile,
	input  layer_pixel_t sprite,
	output color_t       mixed_index
);

	//////////////////////////////////////////////////
	// Priority decision
	//////////////////////////////////////////////////

	// Sprite pen in the low nibble of its color
	logic [3:0] sprite_pen;
	// Sprite pixel carries real color
	logic       sprite_opaque;
	// Sprite priority at least that of the tile
	logic       sprite_above;
	// Final choice for this pixel
	logic       sprite_wins;
	// Color of the winning layer
	color_t     win_color;

	assign sprite_pen = sprite.color[3:0];

	// Pen 15 is see-through on the sprite layer
	assign sprite_opaque = (sprite_pen != TRANSPARENT_PEN);

	// Ties go to the sprite
	assign sprite_above = (sprite.prio >= tile.prio);

	// Both conditions needed, else the tile shows
	assign sprite_wins = sprite_opaque && sprite_above;

	always_comb begin
		if (sprite_wins) begin
			win_color = sprite.color;
		end else begin
			win_color = tile.color;
		end
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	// One cycle of latency into the color lookup
	// Index 0 out of reset
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			mixed_index <= '0;
		end else begin
			mixed_index <= win_color;
		end
	end

endmodule

// File: logic/video_pkg.sv
package video_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Palette color index, one byte per pixel
	localparam int unsigned COLOR_W = 8;
	// Layer priority field
	localparam int unsigned PRIO_W = 3;
	// One palette channel as stored in the PROM
	localparam int unsigned CHAN_W = 4;
	// Output intensity per channel after the ladder
	localparam int unsigned BPP = 8;

	//////////////////////////////////////////////////
	// Palette and pens
	//////////////////////////////////////////////////

	// Two banks of 256 colors
	localparam int unsigned PAL_DEPTH = 512;
	localparam int unsigned PAL_AW = $clog2(PAL_DEPTH);
	// Sprite pen that lets the tile layer show through
	localparam logic [3:0] TRANSPARENT_PEN = 4'hF;

	//////////////////////////////////////////////////
	// Resistor ladder
	//////////////////////////////////////////////////

	// Ohms, channel bit 3 down to bit 0
	localparam int RM1 = 220;
	localparam int RM2 = 470;
	localparam int RM3 = 1000;
	localparam int RM4 = 2200;
	// One table entry per 4-bit channel code
	localparam int unsigned LADDER_CODES = 2 ** CHAN_W;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef logic [COLOR_W-1:0] color_t;
	typedef logic [PRIO_W-1:0] prio_t;

	// Pixel from one video layer
	typedef struct packed {
		color_t color;
		prio_t  prio;
	} layer_pixel_t;

	// Palette load port, addr is {bank, index}
	typedef struct packed {
		logic              we;
		logic [PAL_AW-1:0] addr;
		logic [CHAN_W-1:0] r;
		logic [CHAN_W-1:0] g;
		logic [CHAN_W-1:0] b;
	} palette_wr_t;

	// Final intensities to the monitor
	typedef struct packed {
		logic [BPP-1:0] r;
		logic [BPP-1:0] g;
		logic [BPP-1:0] b;
	} rgb_t;

endpackage

// File: logic/video_top.sv
module video_top import video_pkg::*; (
	input  logic         clk_6m,
	input  logic         rst_n,
	input  layer_pixel_t tile,
	input  layer_pixel_t sprite,
	input  logic         bank,
	input  logic         blank,
	input  palette_wr_t  pal_wr,
	output rgb_t         rgb
);

	//////////////////////////////////////////////////
	// Color output stage
	//////////////////////////////////////////////////

	// Winning color after the mixer register
	color_t mixed_index;

	// Stage one
	// Layer priority and sprite transparency
	pixel_mixer u_mixer (
		.clk_6m      (clk_6m),
		.rst_n       (rst_n),
		.tile        (tile),
		.sprite      (sprite),
		.mixed_index (mixed_index)
	);

	// Stage two
	// Index latch, palette and ladders
	clut u_clut (
		.clk_6m (clk_6m),
		.rst_n  (rst_n),
		.index  (mixed_index),
		.bank   (bank),
		.blank  (blank),
		.pal_wr (pal_wr),
		.rgb    (rgb)
	);

endmodule

// File: sources.f
logic/video_pkg.sv
logic/pixel_mixer.sv
logic/color_ram.sv
logic/dac_ladder.sv
logic/clut.sv
logic/video_top.sv
bench/tb_video_top.sv
